/* list.f */
+incdir+include
hdl/vid_timing_pkg.sv
hdl/pattern_pkg.sv
hdl/vid_timing_gen.sv
hdl/pattern_ctrl_regs.sv
hdl/pattern_vg.sv
hdl/pattern_top.sv
verif/pattern_assert.sv
verif/pattern_tb.sv

/* Makefile */
# Verilator build and run of the pattern testbench

VERILATOR ?= verilator
TOP       ?= pattern_tb
FILELIST  ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	! grep -q "sim failed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/pattern_tb.sv */
`timescale 1ns/1ns
`include "vid_defs.svh"

module pattern_tb;
    import vid_timing_pkg::*;
    import pattern_pkg::*;

    // one frame in clocks, run limit of 12 frames plus slack
    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;
    localparam int MAX_CYC   = 12 * FRAME_CYC + 500;

    // white yellow cyan green magenta red blue black
    localparam logic [23:0] BAR_RGB [8] = '{24'hffffff, 24'hffff00, 24'h00ffff,
        24'h00ff00, 24'hff00ff, 24'hff0000, 24'h0000ff, 24'h000000};

    logic      pix_clk;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    pixel_t    pixel_in;
    vid_sync_t sync_out;
    pixel_t    pixel_out;

    // config as written, and as live in the current frame
    pat_mode_t wr_mode;
    pixel_t    wr_color;
    pat_mode_t cur_mode;
    pixel_t    cur_color;

    vid_sync_t sync_q;
    int        x_cnt;
    int        line_cnt;
    int        hs_cnt;
    int        vs_edges;
    int        cycles;
    int        checks;
    int        errors;
    int        tests;
    int        failed_tests;
    int        test_err0;

    pattern_top dut
    (
        .pix_clk   (pix_clk),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .pixel_in  (pixel_in),
        .sync_out  (sync_out),
        .pixel_out (pixel_out)
    );

    always #10 pix_clk = ~pix_clk;

    ////////////////////////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////////////////////////

    function automatic pixel_t ref_pixel(input pat_mode_t mode, input int x,
                                         input pixel_t colour, input pixel_t in_pixel);
        int         bar;
        logic [2:0] bar_sel;
        logic [7:0] grey;
        bar = x / `BAR_W;
        // leftover columns fold into the last bar
        if (bar > 7)
            bar = 7;
        bar_sel = 3'(bar);
        grey    = 8'((x * 16) & 255);
        case (mode)
            PAT_PASS:  return in_pixel;
            PAT_SOLID: return colour;
            PAT_RAMP:  return '{r: grey, g: grey, b: grey};
            default:   return pixel_t'(BAR_RGB[bar_sel]);
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors != test_err0)
            failed_tests++;
        $display("test %0d %s: %s", tests, name, (errors == test_err0) ? "ok" : "FAILED");
        test_err0 = errors;
    endtask

    // returns once the monitor has seen the next vs rise
    task automatic wait_vsync;
        int n;
        n = vs_edges;
        while (vs_edges == n)
            @(negedge pix_clk);
    endtask

    task automatic wait_active;
        @(negedge pix_clk);
        while (!sync_out.de)
            @(negedge pix_clk);
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input int stall, output logic [1:0] resp);
        @(negedge pix_clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        // no response pending, so address and data go in on this edge
        @(posedge pix_clk);
        check("aw and w ready", {30'h0, axil_rsp.awready, axil_rsp.wready}, 32'h3);
        // bvalid means the address and data were taken
        @(negedge pix_clk);
        while (!axil_rsp.bvalid)
            @(negedge pix_clk);
        // ready was a single cycle pulse
        check("aw and w ready pulse", {30'h0, axil_rsp.awready, axil_rsp.wready}, 32'h0);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        // back-pressure on b
        repeat (stall) @(negedge pix_clk);
        check("bvalid held", {31'h0, axil_rsp.bvalid}, 32'h1);
        resp = axil_rsp.bresp;
        axil_req.bready = 1'b1;
        @(negedge pix_clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp);
        @(negedge pix_clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        // accepted on this edge with no read pending
        @(posedge pix_clk);
        check("arready", {31'h0, axil_rsp.arready}, 32'h1);
        @(negedge pix_clk);
        while (!axil_rsp.rvalid)
            @(negedge pix_clk);
        check("arready pulse", {31'h0, axil_rsp.arready}, 32'h0);
        axil_req.arvalid = 1'b0;
        // back-pressure on r
        repeat (stall) @(negedge pix_clk);
        check("rvalid held", {31'h0, axil_rsp.rvalid}, 32'h1);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.rready = 1'b1;
        @(negedge pix_clk);
        axil_req.rready = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge pix_clk)
    begin : monitor
        pixel_t      exp_pix;
        logic [31:0] rnd;
        if (!reset)
        begin
            // frame boundary, written config goes live
            if (sync_out.vs && !sync_q.vs)
            begin
                check("lines per frame", line_cnt, `V_ACT);
                vs_edges++;
                line_cnt  = 0;
                cur_mode  = wr_mode;
                cur_color = wr_color;
            end
            if (sync_out.de && !sync_q.de)
            begin
                // exactly one hs between two active lines
                if (line_cnt > 0)
                    check("hs per line", hs_cnt, 1);
                hs_cnt = 0;
                x_cnt  = 0;
            end
            if (sync_out.hs && !sync_q.hs)
                hs_cnt++;
            if (sync_out.de)
            begin
                // pixel_in still holds the value driven one cycle back
                exp_pix = ref_pixel(cur_mode, x_cnt, cur_color, pixel_in);
                check("pixel", {8'h0, pixel_out}, {8'h0, exp_pix});
                x_cnt++;
            end
            if (!sync_out.de && sync_q.de)
            begin
                check("pixels per line", x_cnt, `H_ACT);
                line_cnt++;
            end
        end
        sync_q   = sync_out;
        rnd      = $urandom;
        pixel_in = rnd[23:0];
    end

    // run limit
    always @(posedge pix_clk)
    begin
        cycles++;
        if (cycles >= MAX_CYC)
        begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic [31:0] rnd;
        logic [31:0] f0;
        logic [31:0] f1;
        int          e0;
        void'($urandom(32'h697f_9cd6));
        pix_clk   = 1'b0;
        reset     = 1'b1;
        axil_req  = '0;
        pixel_in  = '0;
        wr_mode   = PAT_BARS;
        wr_color  = '0;
        cur_mode  = PAT_BARS;
        cur_color = '0;
        sync_q    = '0;
        x_cnt     = 0;
        line_cnt  = 0;
        hs_cnt    = 0;
        vs_edges  = 0;
        cycles    = 0;
        checks    = 0;
        errors    = 0;
        tests     = 0;
        failed_tests = 0;
        test_err0 = 0;
        repeat (4) @(posedge pix_clk);
        @(negedge pix_clk);
        // video outputs and handshakes idle under reset
        check("reset state", {sync_out, pixel_out, axil_rsp.awready, axil_rsp.wready,
              axil_rsp.bvalid, axil_rsp.arready, axil_rsp.rvalid}, 32'h0);
        reset = 1'b0;

        // default bars over one full frame
        wait_vsync;
        wait_vsync;
        finish_test("bars after reset");

        // solid, then ramp, each written mid frame
        wait_active;
        rnd = $urandom;
        axil_write(`REG_COLOR, {8'h0, rnd[23:0]}, int'($urandom_range(6, 1)), resp);
        check("color write resp", {30'h0, resp}, {30'h0, `AXI_OKAY});
        wr_color = rnd[23:0];
        axil_write(`REG_MODE, 32'(PAT_SOLID), int'($urandom_range(6, 1)), resp);
        check("mode write resp", {30'h0, resp}, {30'h0, `AXI_OKAY});
        wr_mode = PAT_SOLID;
        wait_vsync;
        wait_active;
        axil_write(`REG_MODE, 32'(PAT_RAMP), int'($urandom_range(6, 1)), resp);
        check("mode write resp", {30'h0, resp}, {30'h0, `AXI_OKAY});
        wr_mode = PAT_RAMP;
        wait_vsync;
        finish_test("solid and ramp");

        // random input pixels straight through
        wait_active;
        axil_write(`REG_MODE, 32'(PAT_PASS), int'($urandom_range(6, 1)), resp);
        check("mode write resp", {30'h0, resp}, {30'h0, `AXI_OKAY});
        wr_mode = PAT_PASS;
        wait_vsync;
        wait_vsync;
        finish_test("passthrough");

        // readback, then frame count against seen vs edges
        axil_read(`REG_MODE, int'($urandom_range(6, 1)), rdata, resp);
        check("mode read resp", {30'h0, resp}, {30'h0, `AXI_OKAY});
        check("mode readback", rdata, 32'(PAT_PASS));
        axil_read(`REG_COLOR, int'($urandom_range(6, 1)), rdata, resp);
        check("color read resp", {30'h0, resp}, {30'h0, `AXI_OKAY});
        check("color readback", rdata, {8'h0, wr_color});
        wait_active;
        axil_read(`REG_FRAMES, int'($urandom_range(6, 1)), f0, resp);
        e0 = vs_edges;
        wait_vsync;
        wait_vsync;
        wait_active;
        axil_read(`REG_FRAMES, int'($urandom_range(6, 1)), f1, resp);
        check("frames read resp", {30'h0, resp}, {30'h0, `AXI_OKAY});
        check("frame delta", f1 - f0, 32'(vs_edges - e0));
        finish_test("registers and frames");

        // slverr paths leave the registers alone
        axil_write(`REG_FRAMES, 32'hdead_beef, int'($urandom_range(6, 1)), resp);
        check("frames write resp", {30'h0, resp}, {30'h0, `AXI_SLVERR});
        axil_write(4'hc, 32'h0000_0002, int'($urandom_range(6, 1)), resp);
        check("unknown write resp", {30'h0, resp}, {30'h0, `AXI_SLVERR});
        axil_read(4'hc, int'($urandom_range(6, 1)), rdata, resp);
        check("unknown read resp", {30'h0, resp}, {30'h0, `AXI_SLVERR});
        check("unknown read data", rdata, 32'h0);
        axil_read(`REG_MODE, int'($urandom_range(6, 1)), rdata, resp);
        check("mode after slverr", rdata, 32'(PAT_PASS));
        axil_read(`REG_COLOR, int'($urandom_range(6, 1)), rdata, resp);
        check("color after slverr", rdata, {8'h0, wr_color});
        repeat (4) @(negedge pix_clk);
        finish_test("error responses");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* verif/pattern_assert.sv */
`timescale 1ns/1ns

module pattern_assert
(
    input logic                      pix_clk,
    input logic                      reset,
    input pattern_pkg::axil_req_t    axil_req,
    input pattern_pkg::axil_rsp_t    axil_rsp,
    input vid_timing_pkg::vid_sync_t sync_out,
    input pattern_pkg::pixel_t       pixel_out
);
    // hsync sits in horizontal blanking only
    de_hs_apart: assert property (@(posedge pix_clk) disable iff (reset)
        !(sync_out.de && sync_out.hs))
        else $error("de and hs high in the same cycle");

    // write response stays up until taken
    bvalid_hold: assert property (@(posedge pix_clk) disable iff (reset)
        (axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    // same for the read response
    rvalid_hold: assert property (@(posedge pix_clk) disable iff (reset)
        (axil_rsp.rvalid && !axil_req.rready) |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    // black outside the active area
    blank_black: assert property (@(posedge pix_clk) disable iff (reset)
        sync_out.de || (pixel_out == '0))
        else $error("nonzero pixel with de low");

endmodule

bind pattern_top pattern_assert u_assert
(
    .pix_clk   (pix_clk),
    .reset     (reset),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .sync_out  (sync_out),
    .pixel_out (pixel_out)
);

/* hdl/pattern_top.sv */
`timescale 1ns/1ns

module pattern_top
(
    input  logic                      pix_clk,
    input  logic                      reset,
    input  pattern_pkg::axil_req_t    axil_req,
    output pattern_pkg::axil_rsp_t    axil_rsp,
    input  pattern_pkg::pixel_t       pixel_in,
    output vid_timing_pkg::vid_sync_t sync_out,
    output pattern_pkg::pixel_t       pixel_out
);
    import vid_timing_pkg::*;
    import pattern_pkg::*;

    // raw timing into the pattern stage
    vid_sync_t sync;
    coord_t    act_x;
    coord_t    act_y;
    // shadow configuration, frame aligned
    pat_cfg_t  cfg;

    pattern_ctrl_regs u_regs
    (
        .pix_clk  (pix_clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .vs       (sync.vs),
        .cfg      (cfg)
    );

    vid_timing_gen u_timing
    (
        .pix_clk (pix_clk),
        .reset   (reset),
        .sync    (sync),
        .act_x   (act_x),
        .act_y   (act_y)
    );

    pattern_vg u_pattern
    (
        .pix_clk   (pix_clk),
        .reset     (reset),
        .sync      (sync),
        .act_x     (act_x),
        .act_y     (act_y),
        .pixel_in  (pixel_in),
        .cfg       (cfg),
        .sync_out  (sync_out),
        .pixel_out (pixel_out)
    );

endmodule

/* hdl/pattern_vg.sv */
`timescale 1ns/1ns
`include "vid_defs.svh"

module pattern_vg
(
    input  logic                      pix_clk,
    input  logic                      reset,
    input  vid_timing_pkg::vid_sync_t sync,
    input  vid_timing_pkg::coord_t    act_x,
    input  vid_timing_pkg::coord_t    act_y,
    input  pattern_pkg::pixel_t       pixel_in,
    input  pattern_pkg::pat_cfg_t     cfg,
    output vid_timing_pkg::vid_sync_t sync_out,
    output pattern_pkg::pixel_t       pixel_out
);
    import vid_timing_pkg::*;
    import pattern_pkg::*;

    coord_t     bar_q;
    logic [2:0] bar_idx;
    pixel_t     bar_pix;
    chan_t      ramp_val;
    pixel_t     ramp_pix;
    pixel_t     pix_sel;

    ////////////////////////////////////////////////////////////
    // pattern sources
    ////////////////////////////////////////////////////////////

    // bar index, clamp any leftover columns into the last bar
    assign bar_q   = act_x / coord_t'(`BAR_W);
    assign bar_idx = (bar_q > coord_t'(7)) ? 3'd7 : bar_q[2:0];

    always_comb
    begin
        case (bar_idx)
            3'd0:    bar_pix = pixel_t'(24'hff_ff_ff);
            3'd1:    bar_pix = pixel_t'(24'hff_ff_00);
            3'd2:    bar_pix = pixel_t'(24'h00_ff_ff);
            3'd3:    bar_pix = pixel_t'(24'h00_ff_00);
            3'd4:    bar_pix = pixel_t'(24'hff_00_ff);
            3'd5:    bar_pix = pixel_t'(24'hff_00_00);
            3'd6:    bar_pix = pixel_t'(24'h00_00_ff);
            default: bar_pix = pixel_t'(24'h00_00_00);
        endcase
    end

    // grey ramp, x times 16 truncated to a channel
    assign ramp_val = chan_t'(act_x << 4);
    assign ramp_pix = '{r: ramp_val, g: ramp_val, b: ramp_val};

    always_comb
    begin
        case (cfg.mode)
            PAT_BARS:  pix_sel = bar_pix;
            PAT_SOLID: pix_sel = cfg.color;
            PAT_RAMP:  pix_sel = ramp_pix;
            default:   pix_sel = pixel_in;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // output stage, one cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            sync_out  <= '0;
            pixel_out <= '0;
        end
        else
        begin
            sync_out  <= sync;
            // black in blanking
            pixel_out <= sync.de ? pix_sel : '0;
        end
    end

endmodule

/* hdl/pattern_ctrl_regs.sv */
`timescale 1ns/1ns
`include "vid_defs.svh"

module pattern_ctrl_regs
(
    input  logic                   pix_clk,
    input  logic                   reset,
    input  pattern_pkg::axil_req_t axil_req,
    output pattern_pkg::axil_rsp_t axil_rsp,
    input  logic                   vs,
    output pattern_pkg::pat_cfg_t  cfg
);
    import pattern_pkg::*;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

    wr_state_t  wr_state;
    rd_state_t  rd_state;
    logic       wr_go;
    logic       rd_go;
    pat_mode_t  mode_reg;
    pixel_t     color_reg;
    axil_data_t frame_cnt;
    logic       vs_d;
    logic       vs_rise;
    axil_resp_t bresp_q;
    axil_resp_t rresp_q;
    axil_data_t rdata_q;

    // accept only with no response outstanding
    assign wr_go = (wr_state == WR_IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_go = (rd_state == RD_IDLE) && axil_req.arvalid;

    assign axil_rsp.awready = wr_go;
    assign axil_rsp.wready  = wr_go;
    assign axil_rsp.bvalid  = (wr_state == WR_RESP);
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.arready = rd_go;
    assign axil_rsp.rvalid  = (rd_state == RD_RESP);
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;

    ////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            wr_state  <= WR_IDLE;
            mode_reg  <= PAT_BARS;
            color_reg <= '0;
        end
        else
        begin
            case (wr_state)
                WR_IDLE:
                begin
                    if (wr_go)
                    begin
                        wr_state <= WR_RESP;
                        // frames is read only, unknown addresses ignored
                        if (axil_req.awaddr == `REG_MODE)
                        begin
                            mode_reg <= pat_mode_t'(axil_req.wdata[1:0]);
                        end
                        else if (axil_req.awaddr == `REG_COLOR)
                        begin
                            color_reg <= pixel_t'(axil_req.wdata[23:0]);
                        end
                    end
                end
                WR_RESP:
                begin
                    if (axil_req.bready)
                    begin
                        wr_state <= WR_IDLE;
                    end
                end
                default:
                begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // response code captured with the write
    always_ff @(posedge pix_clk)
    begin
        if (wr_go)
        begin
            if (axil_req.awaddr == `REG_MODE || axil_req.awaddr == `REG_COLOR)
            begin
                bresp_q <= `AXI_OKAY;
            end
            else
            begin
                bresp_q <= `AXI_SLVERR;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            rd_state <= RD_IDLE;
        end
        else if (rd_go)
        begin
            rd_state <= RD_RESP;
        end
        else if (rd_state == RD_RESP && axil_req.rready)
        begin
            rd_state <= RD_IDLE;
        end
    end

    // read data sampled at accept, held while rvalid waits
    always_ff @(posedge pix_clk)
    begin
        if (rd_go)
        begin
            rresp_q <= `AXI_OKAY;
            case (axil_req.araddr)
                `REG_MODE:   rdata_q <= axil_data_t'(mode_reg);
                `REG_COLOR:  rdata_q <= axil_data_t'(color_reg);
                `REG_FRAMES: rdata_q <= frame_cnt;
                default:
                begin
                    rdata_q <= '0;
                    rresp_q <= `AXI_SLVERR;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // vsync edge, frame count and shadow copy
    ////////////////////////////////////////////////////////////

    assign vs_rise = vs && !vs_d;

    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            vs_d      <= 1'b0;
            frame_cnt <= '0;
            cfg       <= '{mode: PAT_BARS, color: '0};
        end
        else
        begin
            vs_d <= vs;
            // pattern only switches at frame boundary
            if (vs_rise)
            begin
                frame_cnt <= frame_cnt + 1'b1;
                cfg       <= '{mode: mode_reg, color: color_reg};
            end
        end
    end

endmodule

/* hdl/vid_timing_gen.sv */
`timescale 1ns/1ns
`include "vid_defs.svh"

module vid_timing_gen
(
    input  logic                      pix_clk,
    input  logic                      reset,
    output vid_timing_pkg::vid_sync_t sync,
    output vid_timing_pkg::coord_t    act_x,
    output vid_timing_pkg::coord_t    act_y
);
    import vid_timing_pkg::*;

    // sync windows on the raw counters
    localparam coord_t HS_START = coord_t'(`H_ACT + `H_FP);
    localparam coord_t HS_END   = coord_t'(`H_ACT + `H_FP + `H_SYNC);
    localparam coord_t VS_START = coord_t'(`V_ACT + `V_FP);
    localparam coord_t VS_END   = coord_t'(`V_ACT + `V_FP + `V_SYNC);

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;
    logic   h_act;
    logic   v_act;

    assign h_last = (h_cnt == coord_t'(`H_TOTAL - 1));
    assign v_last = (v_cnt == coord_t'(`V_TOTAL - 1));
    assign h_act  = (h_cnt < coord_t'(`H_ACT));
    assign v_act  = (v_cnt < coord_t'(`V_ACT));

    ////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            // line done, step or wrap the frame
            if (v_last)
            begin
                v_cnt <= '0;
            end
            else
            begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered strobes and coordinates
    ////////////////////////////////////////////////////////////

    always_ff @(posedge pix_clk)
    begin
        if (reset)
        begin
            sync  <= '0;
            act_x <= '0;
            act_y <= '0;
        end
        else
        begin
            sync.de <= h_act && v_act;
            sync.hs <= (h_cnt >= HS_START) && (h_cnt < HS_END);
            sync.vs <= (v_cnt >= VS_START) && (v_cnt < VS_END);
            // coordinates freeze in blanking
            if (h_act)
            begin
                act_x <= h_cnt;
            end
            if (v_act)
            begin
                act_y <= v_cnt;
            end
        end
    end

endmodule

/* hdl/pattern_pkg.sv */
package pattern_pkg;

    ////////////////////////////////////////////////////////////
    // pixel and pattern types
    ////////////////////////////////////////////////////////////

    // one colour channel
    typedef logic [7:0] chan_t;

    // r in the top byte, b in the bottom
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pixel_t;

    typedef enum logic [1:0] {
        PAT_PASS  = 2'd0,
        PAT_BARS  = 2'd1,
        PAT_SOLID = 2'd2,
        PAT_RAMP  = 2'd3
    } pat_mode_t;

    // configuration as seen by the pattern stage
    typedef struct packed {
        pat_mode_t mode;
        pixel_t    color;
    } pat_cfg_t;

    ////////////////////////////////////////////////////////////
    // axi4-lite channels
    ////////////////////////////////////////////////////////////

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    // host to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // slave to host
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

endpackage

/* hdl/vid_timing_pkg.sv */
package vid_timing_pkg;

    // one raster coordinate, wide enough for 4k timings
    typedef logic [12:0] coord_t;

    // sync strobes, all active high
    typedef struct packed {
        logic vs;
        logic hs;
        logic de;
    } vid_sync_t;

endpackage

/* include/vid_defs.svh */
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// horizontal geometry in pixel clocks
`define H_ACT      16
`define H_FP       2
`define H_SYNC     2
`define H_BP       2
`define H_TOTAL    (`H_ACT + `H_FP + `H_SYNC + `H_BP)

// vertical geometry in lines
`define V_ACT      4
`define V_FP       1
`define V_SYNC     1
`define V_BP       1
`define V_TOTAL    (`V_ACT + `V_FP + `V_SYNC + `V_BP)

// eight colour bars across the active width
`define BAR_W      (`H_ACT / 8)

// register map, byte addresses
`define REG_MODE   4'h0
`define REG_COLOR  4'h4
`define REG_FRAMES 4'h8

// axi response codes
`define AXI_OKAY   2'b00
`define AXI_SLVERR 2'b10

`endif
